/* hdl/mxu_pkg.sv */
package mxu_pkg;

   localparam int data_width_max = 32;   // widest word the lane functions handle

   typedef enum logic {
      PREC_FULL = 1'b0,   // one lane of data_width bits
      PREC_HALF = 1'b1    // two lanes of data_width/2 bits
   } prec_e;

   //////////////////////////////////////////////////////////////////////
   // lane-wise arithmetic, every lane wraps at its own width
   //////////////////////////////////////////////////////////////////////

   function automatic logic [data_width_max-1:0] lane_mul(
      input logic [data_width_max-1:0] a,
      input logic [data_width_max-1:0] b,
      input prec_e                     prec,
      input int                        width
   );
      logic [data_width_max-1:0] mask;
      logic [data_width_max-1:0] half_mask;
      logic [data_width_max-1:0] full;
      logic [data_width_max-1:0] lo;
      logic [data_width_max-1:0] hi;
      int                        half;
      half      = width / 2;
      mask      = {data_width_max{1'b1}} >> (data_width_max - width);
      half_mask = {data_width_max{1'b1}} >> (data_width_max - half);
      full      = (a * b) & mask;
      lo        = ((a & half_mask) * (b & half_mask)) & half_mask;
      hi        = (((a >> half) & half_mask) * ((b >> half) & half_mask)) & half_mask;
      return (prec == PREC_HALF) ? (lo | (hi << half)) : full;
   endfunction

   function automatic logic [data_width_max-1:0] lane_mac(
      input logic [data_width_max-1:0] psum,
      input logic [data_width_max-1:0] a,
      input logic [data_width_max-1:0] b,
      input prec_e                     prec,
      input int                        width
   );
      logic [data_width_max-1:0] mask;
      logic [data_width_max-1:0] half_mask;
      logic [data_width_max-1:0] prod;
      logic [data_width_max-1:0] full;
      logic [data_width_max-1:0] lo;
      logic [data_width_max-1:0] hi;
      int                        half;
      half      = width / 2;
      mask      = {data_width_max{1'b1}} >> (data_width_max - width);
      half_mask = {data_width_max{1'b1}} >> (data_width_max - half);
      prod      = lane_mul(a, b, prec, width);
      full      = (psum + prod) & mask;
      // low lane sum masked before the high lane is added, so no carry crosses
      lo        = ((psum & half_mask) + (prod & half_mask)) & half_mask;
      hi        = (((psum >> half) & half_mask) + ((prod >> half) & half_mask)) & half_mask;
      return (prec == PREC_HALF) ? (lo | (hi << half)) : full;
   endfunction

endpackage

/* hdl/mxu_mult.sv */
`timescale 1ns/1ps

// first column of a row, no partial sum comes in from the left
module mxu_mult #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  mxu_pkg::prec_e        precision,
   input  logic [data_width-1:0] data_in,
   input  logic [data_width-1:0] weight,
   output logic [data_width-1:0] prod,
   output logic [data_width-1:0] data_down
);

   import mxu_pkg::*;

   logic [data_width_max-1:0] prod_wide;   // product at package width

   assign prod_wide = lane_mul(data_width_max'(data_in),
                               data_width_max'(weight),
                               precision,
                               data_width);

   //////////////////////////////////////////////////////////////////////
   // product register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         prod <= '0;
      end else if (enable) begin
         prod <= prod_wide[data_width-1:0];   // wraps per lane
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data element for the row below
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         data_down <= '0;
      end else if (enable) begin
         data_down <= data_in;   // one row per cycle
      end
   end

endmodule

/* hdl/mxu_mac.sv */
`timescale 1ns/1ps

// interior cell of the grid
// partial sum arrives from the left neighbour, leaves to the right
module mxu_mac #(
   parameter int data_width = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  enable,
   input  mxu_pkg::prec_e        precision,
   input  logic [data_width-1:0] data_in,
   input  logic [data_width-1:0] weight,
   input  logic [data_width-1:0] psum_in,
   output logic [data_width-1:0] psum_out,
   output logic [data_width-1:0] data_down
);

   import mxu_pkg::*;

   logic [data_width_max-1:0] psum_next;   // lane-wise psum_in + data*weight

   assign psum_next = lane_mac(data_width_max'(psum_in),
                               data_width_max'(data_in),
                               data_width_max'(weight),
                               precision,
                               data_width);

   //////////////////////////////////////////////////////////////////////
   // partial sum register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         psum_out <= '0;
      end else if (enable) begin
         // psum_in is one cycle later than the left neighbour's data,
         // matching the one row of skew on the data side
         psum_out <= psum_next[data_width-1:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data element forwarded one row down
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         data_down <= '0;
      end else if (enable) begin
         data_down <= data_in;
      end
   end

endmodule

/* hdl/mxu_core.sv */
`timescale 1ns/1ps

module mxu_core #(
   parameter int rows       = 3,
   parameter int cols       = 3,
   parameter int data_width = 8
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       enable,
   input  logic                       weight_load,
   input  mxu_pkg::prec_e             precision,
   input  logic [rows*data_width-1:0] weight,
   input  logic [cols*data_width-1:0] x_skewed,
   output logic [rows*data_width-1:0] y_raw
);

   import mxu_pkg::*;

   logic [data_width-1:0] w_reg [0:rows-1];           // one weight per row
   prec_e                 prec_reg;
   logic [data_width-1:0] dat   [0:rows][0:cols-1];   // data chain, row index first
   logic [data_width-1:0] psum  [0:rows-1][0:cols-1]; // partial sums along a row

   //////////////////////////////////////////////////////////////////////
   // weight and precision latch
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         prec_reg <= PREC_FULL;
         for (int r = 0; r < rows; r++) begin
            w_reg[r] <= '0;
         end
      end else if (enable && weight_load) begin
         prec_reg <= precision;
         for (int r = 0; r < rows; r++) begin
            w_reg[r] <= weight[r*data_width +: data_width];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // cell grid
   //////////////////////////////////////////////////////////////////////

   genvar i, j;
   generate
      for (j = 0; j < cols; j++) begin : g_top_in
         assign dat[0][j] = x_skewed[j*data_width +: data_width];   // row 0 feed
      end

      for (i = 0; i < rows; i++) begin : g_row
         for (j = 0; j < cols; j++) begin : g_col
            if (j == 0) begin : g_mult
               mxu_mult #(.data_width(data_width)) u_mult (
                  .clk       (clk),
                  .rst       (rst),
                  .enable    (enable),
                  .precision (prec_reg),
                  .data_in   (dat[i][j]),
                  .weight    (w_reg[i]),
                  .prod      (psum[i][j]),
                  .data_down (dat[i+1][j])
               );
            end else begin : g_mac
               mxu_mac #(.data_width(data_width)) u_mac (
                  .clk       (clk),
                  .rst       (rst),
                  .enable    (enable),
                  .precision (prec_reg),
                  .data_in   (dat[i][j]),
                  .weight    (w_reg[i]),
                  .psum_in   (psum[i][j-1]),
                  .psum_out  (psum[i][j]),
                  .data_down (dat[i+1][j])
               );
            end
         end
         assign y_raw[i*data_width +: data_width] = psum[i][cols-1];   // row result
      end
   endgenerate

endmodule

/* hdl/mxu_skew.sv */
`timescale 1ns/1ps

// triangular delay line
// lane n is delayed by n cycles, or by lanes-1-n when reverse is set
module mxu_skew #(
   parameter int lanes      = 3,
   parameter int data_width = 8,
   parameter bit reverse    = 1'b0
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        enable,
   input  logic [lanes*data_width-1:0] din,
   output logic [lanes*data_width-1:0] dout
);

   genvar n;
   generate
      for (n = 0; n < lanes; n++) begin : g_lane
         localparam int depth = reverse ? (lanes - 1 - n) : n;

         if (depth == 0) begin : g_wire
            assign dout[n*data_width +: data_width] = din[n*data_width +: data_width];
         end else begin : g_pipe
            logic [data_width-1:0] stage [0:depth-1];   // stage 0 nearest the input

            always_ff @(posedge clk) begin
               if (rst) begin
                  for (int s = 0; s < depth; s++) begin
                     stage[s] <= '0;
                  end
               end else if (enable) begin
                  stage[0] <= din[n*data_width +: data_width];
                  for (int s = 1; s < depth; s++) begin
                     stage[s] <= stage[s-1];
                  end
               end
            end

            assign dout[n*data_width +: data_width] = stage[depth-1];
         end
      end
   endgenerate

endmodule

/* hdl/mxu_top.sv */
`timescale 1ns/1ps

module mxu_top #(
   parameter int rows       = 3,
   parameter int cols       = 3,
   parameter int data_width = 8   // must be even for half mode
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [cols*data_width-1:0] x_data,
   input  logic                       x_valid,
   input  logic [rows*data_width-1:0] weight,
   input  logic                       weight_load,
   input  mxu_pkg::prec_e             precision,
   input  logic                       enable,
   output logic [rows*data_width-1:0] y_data,
   output logic                       y_valid
);

   localparam int latency = rows + cols - 1;   // skew + grid + deskew

   logic [cols*data_width-1:0] x_skewed;
   logic [rows*data_width-1:0] y_raw;
   logic [latency-1:0]         valid_sr;        // bit 0 is the newest

   //////////////////////////////////////////////////////////////////////
   // datapath: skew, grid, deskew
   //////////////////////////////////////////////////////////////////////

   mxu_skew #(
      .lanes      (cols),
      .data_width (data_width),
      .reverse    (1'b0)
   ) u_skew (
      .clk    (clk),
      .rst    (rst),
      .enable (enable),
      .din    (x_data),
      .dout   (x_skewed)
   );

   mxu_core #(
      .rows       (rows),
      .cols       (cols),
      .data_width (data_width)
   ) u_core (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .weight_load (weight_load),
      .precision   (precision),
      .weight      (weight),
      .x_skewed    (x_skewed),
      .y_raw       (y_raw)
   );

   mxu_skew #(
      .lanes      (rows),
      .data_width (data_width),
      .reverse    (1'b1)        // lower rows finish later, wait less
   ) u_deskew (
      .clk    (clk),
      .rst    (rst),
      .enable (enable),
      .din    (y_raw),
      .dout   (y_data)
   );

   //////////////////////////////////////////////////////////////////////
   // valid pipeline
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_sr <= '0;
      end else if (enable) begin
         valid_sr[0] <= x_valid;
         for (int k = 1; k < latency; k++) begin
            valid_sr[k] <= valid_sr[k-1];
         end
      end
   end

   assign y_valid = valid_sr[latency-1];   // held while enable is low

endmodule

/* bench/mxu_tb.sv */
`timescale 1ns/1ps

module mxu_tb;

   import mxu_pkg::*;

   localparam int rows        = 3;
   localparam int cols        = 3;
   localparam int data_width  = 8;
   localparam int hw          = data_width / 2;   // half-mode lane width
   localparam int latency     = rows + cols - 1;  // enabled cycles from vector to result
   // all vectors, gap and stall tests counted twice, plus drains and margin
   localparam int cycle_limit = 28 + 350 + 2 * 420 + 8 * (latency + 6) + 600;

   logic                       clk = 1'b0;
   logic                       rst;
   logic [cols*data_width-1:0] x_data;
   logic                       x_valid;
   logic [rows*data_width-1:0] weight;
   logic                       weight_load;
   prec_e                      precision;
   logic                       enable;
   logic [rows*data_width-1:0] y_data;
   logic                       y_valid;

   integer                     seed = 32'he280cec6;
   string                      cur_test = "reset";
   logic [rows*data_width-1:0] exp_q [$];      // expected vectors, oldest first
   int                         stamp_q [$];    // enabled-edge count when each entered
   logic [rows*data_width-1:0] mdl_w;
   logic [rows*data_width-1:0] exp_vec;
   logic [rows*data_width-1:0] hold_data;
   prec_e                      mdl_prec;
   logic                       adv;            // last edge moved the pipeline
   logic                       hold_valid;
   int                         ecount;
   int                         pushed;
   int                         popped;
   int                         cycles;
   int                         exp_stamp;
   int                         err_value;
   int                         err_proto;
   int                         err_prec;

   mxu_top #(.rows(rows), .cols(cols), .data_width(data_width)) u_dut (.*);

   always #20 clk = ~clk;

   ///////////////////////////////////////////////////////////////////////
   // model and compare
   ///////////////////////////////////////////////////////////////////////

   function automatic logic [cols*data_width-1:0] random_x();
      logic [cols*data_width-1:0] v;
      for (int j = 0; j < cols; j++) begin
         v[j*data_width +: data_width] = data_width'($random(seed));
      end
      return v;
   endfunction

   function automatic logic [rows*data_width-1:0] random_w();
      logic [rows*data_width-1:0] v;
      for (int r = 0; r < rows; r++) begin
         v[r*data_width +: data_width] = data_width'($random(seed));
      end
      return v;
   endfunction

   // row result is its weight times the column sum, wrapped per lane
   function automatic logic [rows*data_width-1:0] expected_vector(
      input logic [cols*data_width-1:0] x,
      input logic [rows*data_width-1:0] w,
      input prec_e                      p
   );
      logic [rows*data_width-1:0] y;
      logic [63:0]                sum_all;
      logic [63:0]                sum_lo;
      logic [63:0]                sum_hi;
      y       = '0;
      sum_all = '0;
      sum_lo  = '0;
      sum_hi  = '0;
      for (int j = 0; j < cols; j++) begin
         sum_all = sum_all + 64'(x[j*data_width +: data_width]);
         sum_lo  = sum_lo + 64'(x[j*data_width +: hw]);
         sum_hi  = sum_hi + 64'(x[j*data_width + hw +: hw]);
      end
      for (int r = 0; r < rows; r++) begin
         if (p == PREC_HALF) begin
            y[r*data_width +: hw]      = hw'(sum_lo * 64'(w[r*data_width +: hw]));
            y[r*data_width + hw +: hw] = hw'(sum_hi * 64'(w[r*data_width + hw +: hw]));
         end else begin
            y[r*data_width +: data_width] = data_width'(sum_all * 64'(w[r*data_width +: data_width]));
         end
      end
      return y;
   endfunction

   task automatic check_row(input string name, input int row,
                            input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
      if (actual !== expected) begin
         err_value++;
         $display("FAIL %s row %0d expected %h actual %h", name, row, expected, actual);
      end
   endtask

   task automatic check_prec(input string name, input prec_e expected, input prec_e actual);
      if (actual !== expected) begin
         err_prec++;
         $display("FAIL %s precision expected %s actual %s", name, expected.name(), actual.name());
      end
   endtask

   // sample inputs on the rising edge as the DUT does, outputs at the falling edge
   always begin
      @(posedge clk);
      if (rst) begin
         mdl_w    = '0;
         mdl_prec = PREC_FULL;
         adv      = 1'b0;
      end else begin
         adv = enable;
         if (enable && x_valid) begin
            exp_q.push_back(expected_vector(x_data, mdl_w, mdl_prec));
            stamp_q.push_back(ecount);
            pushed++;
         end
         if (enable && weight_load) begin
            mdl_w    = weight;
            mdl_prec = precision;
         end
         if (enable) begin
            ecount++;
         end
      end
      @(negedge clk);
      if (rst) begin
         if (y_valid !== 1'b0) begin
            err_proto++;
            $display("y_valid is high during reset");
         end
      end else if (!adv) begin
         if (y_valid !== hold_valid || y_data !== hold_data) begin
            err_proto++;
            $display("outputs changed while enable was low at %0t", $time);
         end
      end else if (y_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            err_proto++;
            $display("y_valid high with no result expected in %s", cur_test);
         end else begin
            exp_vec   = exp_q.pop_front();
            exp_stamp = stamp_q.pop_front();
            popped++;
            if (ecount - exp_stamp != latency) begin
               err_proto++;
               $display("result in %s took %0d enabled cycles instead of %0d",
                        cur_test, ecount - exp_stamp, latency);
            end
            for (int r = 0; r < rows; r++)
               check_row(cur_test, r, exp_vec[r*data_width +: data_width],
                         y_data[r*data_width +: data_width]);
         end
      end
      hold_valid = y_valid;
      hold_data  = y_data;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("run stopped after %0d cycles with %0d results outstanding",
                  cycles, pushed - popped);
         $display("Regression failed");
         $finish;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // stimulus
   ///////////////////////////////////////////////////////////////////////

   task automatic drive(input logic v, input logic e);
      @(posedge clk);
      x_data      <= random_x();
      x_valid     <= v;
      enable      <= e;
      weight_load <= 1'b0;
   endtask

   task automatic drain();
      drive(1'b0, 1'b1);
      @(posedge clk);
      while (pushed != popped) begin   // no more pushes once idle is sampled
         @(posedge clk);
      end
   endtask

   // gap and stall odds are out of 8
   task automatic stream(input int count, input int gap_in_8, input int stall_in_8);
      int   accepted;
      logic v;
      logic e;
      accepted = 0;
      while (accepted < count) begin
         v = (($random(seed) & 7) >= gap_in_8);
         e = (($random(seed) & 7) >= stall_in_8);
         drive(v, e);
         if (v && e) accepted++;
      end
      drain();
   endtask

   task automatic load(input prec_e p);
      drain();
      weight      <= random_w();
      precision   <= p;
      weight_load <= 1'b1;
      enable      <= 1'b1;
      @(posedge clk);
      weight_load <= 1'b0;
      @(negedge clk);
      check_prec(cur_test, p, u_dut.u_core.prec_reg);   // mode latched in the grid
   endtask

   initial begin
      rst         <= 1'b1;
      enable      <= 1'b0;
      x_data      <= '0;
      x_valid     <= 1'b0;
      weight      <= '0;
      weight_load <= 1'b0;
      precision   <= PREC_FULL;
      repeat (8) @(posedge clk);
      rst         <= 1'b0;
      enable      <= 1'b1;
      stream(4, 0, 0);                     // weights still zero from reset
      cur_test = "full_stream";
      load(PREC_FULL);
      stream(200, 0, 0);
      cur_test = "half_prec";
      load(PREC_HALF);
      stream(150, 0, 0);
      cur_test = "gaps";
      load(PREC_FULL);
      stream(150, 2, 0);
      cur_test = "stalls";
      stream(150, 1, 2);
      cur_test = "reload";
      load(PREC_HALF);
      stream(60, 1, 1);
      load(PREC_FULL);
      stream(60, 0, 0);
      $display("errors: %0d value, %0d protocol, %0d precision", err_value, err_proto, err_prec);
      if (err_value + err_proto + err_prec == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* mxu.f */
hdl/mxu_pkg.sv
hdl/mxu_mult.sv
hdl/mxu_mac.sv
hdl/mxu_core.sv
hdl/mxu_skew.sv
hdl/mxu_top.sv
bench/mxu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mxu testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module mxu_tb -f mxu.f -o mxu_sim; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/mxu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
